/* Makefile */
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing
TOP        ?= tb_rom_guard
RTL_TOP    ?= rom_guard_top
FILELIST   ?= rom_guard.f
OBJ_DIR    ?= obj_dir

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* common/rom_guard_defs.svh */
// ================================================
// Guarded boot ROM shared constants
// ROM geometry, scramble keys, multi-bit
// select encodings and the APB status address
// ================================================

`ifndef ROM_GUARD_DEFS_SVH
`define ROM_GUARD_DEFS_SVH

// ROM geometry
`define ROM_AW 5
`define ROM_WORDS 32
`define ROM_DW 39

// Address scramble key, XORed onto the logical row
`define ROM_ADDR_KEY 5'h13

// Keystream base, rotated left by the logical address
`define ROM_DATA_KEY 39'h5A_3C96_E1D7

// Multi-bit select encodings, anything else is invalid
`define SEL_TRUE 4'hA
`define SEL_FALSE 4'h5

// Byte address of the status word
`define STATUS_ADDR 8'h80

`endif

/* common/rom_guard_pkg.sv */
// ================================================
// Guarded boot ROM package
// Select type, ROM word views and the keystream,
// check-code and digest helpers
// ================================================

`default_nettype none

`include "rom_guard_defs.svh"

package rom_guard_pkg;

  // Multi-bit select or enable
  typedef logic [3:0] sel4_t;

  // Raw view for the digest, field view for the bus side
  typedef union packed {
    logic [`ROM_DW-1:0] raw;
    struct packed {
      logic [6:0]  ecc;
      logic [31:0] data;
    } fields;
  } rom_word_u;

  // Data key rotated left by the logical address
  function automatic logic [`ROM_DW-1:0] keystream(input logic [`ROM_AW-1:0] addr);
    logic [2*`ROM_DW-1:0] dbl;
    dbl = {`ROM_DATA_KEY, `ROM_DATA_KEY} << addr;
    // Upper half holds the rotated key
    return dbl[2*`ROM_DW-1:`ROM_DW];
  endfunction

  // Byte fold of the data word, low 7 bits kept
  function automatic logic [6:0] ecc_code(input logic [31:0] data);
    logic [7:0] fold;
    fold = data[31:24] ^ data[23:16] ^ data[15:8] ^ data[7:0];
    return fold[6:0];
  endfunction

  // One digest step: rotate left by one, then fold in the word
  function automatic logic [`ROM_DW-1:0] digest_step(input logic [`ROM_DW-1:0] digest,
                                                     input logic [`ROM_DW-1:0] word);
    return {digest[`ROM_DW-2:0], digest[`ROM_DW-1]} ^ word;
  endfunction

endpackage

`default_nettype wire

/* rom_ctrl/rom_guard_checker.sv */
// ================================================
// ROM startup checker
// Reads every row once, folds rows into a digest,
// compares it with the digest row and drives the
// select of the ROM port mux
// ================================================

`default_nettype none

`include "rom_guard_defs.svh"

module rom_guard_checker
  import rom_guard_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_ni,
  input  sel4_t              lc_bus_en_i,
  output logic [`ROM_AW-1:0] chk_addr_o,
  output logic               chk_req_o,
  input  logic [`ROM_DW-1:0] chk_rdata_i,
  output sel4_t              sel_bus_o,
  output logic               chk_done_o,
  output logic               chk_pass_o
);

  // FSM encodings
  localparam logic [1:0] ST_READ      = 2'd0;
  localparam logic [1:0] ST_WAIT_LAST = 2'd1;
  localparam logic [1:0] ST_COMPARE   = 2'd2;
  localparam logic [1:0] ST_DONE      = 2'd3;

  // Row that holds the stored digest
  localparam logic [`ROM_AW-1:0] LAST_ROW = `ROM_AW'(`ROM_WORDS - 1);

  logic [1:0]         state_q;
  logic [`ROM_AW-1:0] addr_q;
  logic               rsp_valid_q;
  logic [`ROM_DW-1:0] digest_q;
  logic [`ROM_DW-1:0] exp_q;
  logic               pass_q;
  logic               fold_en;

  // One request per cycle while reading
  assign chk_req_o  = (state_q == ST_READ);
  assign chk_addr_o = addr_q;

  // Responses seen in the read state are rows 0 to 30
  assign fold_en = rsp_valid_q && (state_q == ST_READ);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= ST_READ;
      addr_q      <= '0;
      rsp_valid_q <= 1'b0;
      digest_q    <= '0;
      pass_q      <= 1'b0;
    end else begin
      rsp_valid_q <= chk_req_o;
      if (fold_en) begin
        digest_q <= digest_step(digest_q, chk_rdata_i);
      end
      case (state_q)
        ST_READ: begin
          addr_q <= addr_q + 1'b1;
          if (addr_q == LAST_ROW) begin
            state_q <= ST_WAIT_LAST;
          end
        end
        // Digest row arrives here
        ST_WAIT_LAST: begin
          state_q <= ST_COMPARE;
        end
        ST_COMPARE: begin
          pass_q  <= (digest_q == exp_q);
          state_q <= ST_DONE;
        end
        default: begin
          state_q <= ST_DONE;
        end
      endcase
    end
  end

  // Stored digest captured from the last row
  always_ff @(posedge clk_i) begin
    if (state_q == ST_WAIT_LAST) begin
      exp_q <= chk_rdata_i;
    end
  end

  assign chk_done_o = (state_q == ST_DONE);
  assign chk_pass_o = pass_q;

  // Enable passed through as is, the mux judges its encoding
  assign sel_bus_o = (chk_done_o && pass_q) ? lc_bus_en_i : `SEL_FALSE;

endmodule

`default_nettype wire

/* rom_ctrl/rom_guard_mem.sv */
// ================================================
// Scrambled ROM array
// One-cycle read returning the stored row and
// the row descrambled with the address keystream
// ================================================

`default_nettype none

`include "rom_guard_defs.svh"

module rom_guard_mem
  import rom_guard_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic [`ROM_AW-1:0] rom_addr_i,
  input  logic [`ROM_AW-1:0] prince_addr_i,
  input  logic               req_i,
  output logic [`ROM_DW-1:0] scr_rdata_o,
  output logic [`ROM_DW-1:0] clr_rdata_o,
  output logic               rvalid_o
);

  logic [`ROM_DW-1:0] mem [`ROM_WORDS];
  logic [`ROM_DW-1:0] scr_q;
  logic [`ROM_DW-1:0] ks_q;
  logic               rvalid_q;

  // Image holds scrambled words at physical rows
  initial begin
    $readmemh("rom_init.hex", mem);
  end

  // Row and keystream latched together on a request
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      scr_q <= mem[rom_addr_i];
      ks_q  <= keystream(prince_addr_i);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i;
    end
  end

  assign scr_rdata_o = scr_q;
  assign clr_rdata_o = scr_q ^ ks_q;
  assign rvalid_o    = rvalid_q;

endmodule

`default_nettype wire

/* rom_ctrl/rom_guard_mux.sv */
// ================================================
// ROM port select mux
// One-way switch of the ROM port from the startup
// checker to the bus, with a sticky alert on bad
// or reverting select values
// ================================================

`default_nettype none

`include "rom_guard_defs.svh"

module rom_guard_mux
  import rom_guard_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_ni,

  // Select from the checker, True hands the port to the bus
  input  sel4_t              sel_bus_i,

  // Bus side
  input  logic [`ROM_AW-1:0] bus_rom_addr_i,
  input  logic [`ROM_AW-1:0] bus_prince_addr_i,
  input  logic               bus_req_i,
  output logic               bus_gnt_o,
  output logic [`ROM_DW-1:0] bus_rdata_o,
  output logic               bus_rvalid_o,

  // Checker side
  input  logic [`ROM_AW-1:0] chk_addr_i,
  input  logic               chk_req_i,
  output logic [`ROM_DW-1:0] chk_rdata_o,

  // ROM side
  output logic [`ROM_AW-1:0] rom_rom_addr_o,
  output logic [`ROM_AW-1:0] rom_prince_addr_o,
  output logic               rom_req_o,
  input  logic [`ROM_DW-1:0] rom_scr_rdata_i,
  input  logic [`ROM_DW-1:0] rom_clr_rdata_i,
  input  logic               rom_rvalid_i,

  output logic               alert_o
);

  // True when the value is neither encoding
  function automatic logic sel_invalid_f(input sel4_t sel);
    return (sel != `SEL_TRUE) && (sel != `SEL_FALSE);
  endfunction

  sel4_t sel_bus_q;
  sel4_t sel_bus_qq;
  sel4_t sel_bus_eff;
  logic  bus_sel;
  logic  sel_invalid;
  logic  sel_reverted;
  logic  sel_q_reverted;
  logic  alert_q;

  // Select seen this cycle, can only move toward True
  assign sel_bus_eff = (sel_bus_i == `SEL_TRUE) ? `SEL_TRUE : sel_bus_q;
  assign bus_sel     = (sel_bus_eff == `SEL_TRUE);

  // Registered select plus a delayed copy for the revert check
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sel_bus_q  <= `SEL_FALSE;
      sel_bus_qq <= `SEL_FALSE;
    end else begin
      sel_bus_q  <= sel_bus_eff;
      sel_bus_qq <= sel_bus_q;
    end
  end

  // Corrupt encoding on the input or in the register
  assign sel_invalid = sel_invalid_f(sel_bus_i) || sel_invalid_f(sel_bus_q);

  // Checker tries to take the port back
  assign sel_reverted = (sel_bus_q == `SEL_TRUE) && (sel_bus_i == `SEL_FALSE);

  // Register itself flipped back from True
  assign sel_q_reverted = (sel_bus_qq == `SEL_TRUE) && (sel_bus_q == `SEL_FALSE);

  // Sticky until reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      alert_q <= 1'b0;
    end else begin
      alert_q <= alert_q | sel_invalid | sel_reverted | sel_q_reverted;
    end
  end

  assign alert_o = alert_q;

  // Grant every cycle once the port belongs to the bus
  assign bus_gnt_o    = bus_sel;
  assign bus_rdata_o  = rom_clr_rdata_i;
  // Response belongs to the bus if the port was the bus's last cycle
  assign bus_rvalid_o = (sel_bus_q == `SEL_TRUE) & rom_rvalid_i;

  // Checker digests the stored words as they are
  assign chk_rdata_o = rom_scr_rdata_i;

  assign rom_req_o         = bus_sel ? bus_req_i         : chk_req_i;
  assign rom_rom_addr_o    = bus_sel ? bus_rom_addr_i    : chk_addr_i;
  assign rom_prince_addr_o = bus_sel ? bus_prince_addr_i : chk_addr_i;

endmodule

`default_nettype wire

/* rom_guard.f */
+incdir+common
common/rom_guard_pkg.sv
rom_ctrl/rom_guard_mux.sv
rom_ctrl/rom_guard_checker.sv
rom_ctrl/rom_guard_mem.sv
rtl/rom_guard_apb.sv
rtl/rom_guard_top.sv
verif/tb_rom_guard.sv

/* rom_init.hex */
// One 39-bit scrambled word per physical row, rows 0 to 31
// Row 31 holds the digest of rows 0 to 30
1234567012
2468ACE024
3072615243
60E4C2A486
0765432107
0ECA86420E
2143657021
4286CAE042
1357024613
26AE048C26
3210765432
6420ECA864
0536271405
0A6C4E280A
2604715371
4C08E2A6E2
1111222233
2222444466
6917515BD7
522EA2B7AF
3456701234
68ACE02468
0172635405
02E4C6A80A
2777000111
4EEE000222
1020304050
20406080A0
3303301230
6606602460
2A5F01C3E9
2A5F01C3E9

/* rtl/rom_guard_apb.sv */
// ================================================
// APB slave for the guarded ROM
// Turns reads into ROM bus requests, checks the
// returned code bits and serves the status word
// ================================================

`default_nettype none

`include "rom_guard_defs.svh"

module rom_guard_apb
  import rom_guard_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_ni,

  // APB slave
  input  logic [7:0]         paddr_i,
  input  logic               psel_i,
  input  logic               penable_i,
  input  logic               pwrite_i,
  input  logic [31:0]        pwdata_i,
  output logic [31:0]        prdata_o,
  output logic               pready_o,
  output logic               pslverr_o,

  // Status sources
  input  logic               chk_done_i,
  input  logic               chk_pass_i,
  input  logic               alert_i,

  // ROM bus
  output logic [`ROM_AW-1:0] bus_rom_addr_o,
  output logic [`ROM_AW-1:0] bus_prince_addr_o,
  output logic               bus_req_o,
  input  logic               bus_gnt_i,
  input  logic [`ROM_DW-1:0] bus_rdata_i,
  input  logic               bus_rvalid_i
);

  logic               access;
  logic               is_status;
  logic               rom_rd;
  logic               busy;
  logic               imm_ready;
  logic [`ROM_AW-1:0] word_addr;
  rom_word_u          rd_word;
  logic               ecc_bad;
  logic               rsp_take;
  logic               pend_q;
  logic               rsp_q;
  logic               rsp_err_q;
  logic [31:0]        rsp_data_q;

  assign access    = psel_i & penable_i;
  assign is_status = (paddr_i == `STATUS_ADDR);
  assign rom_rd    = ~pwrite_i & ~is_status;
  // A ROM read is in flight or waiting to answer
  assign busy      = pend_q | rsp_q;

  // Word index from the byte address
  assign word_addr         = paddr_i[6:2];
  assign bus_prince_addr_o = word_addr;
  assign bus_rom_addr_o    = word_addr ^ `ROM_ADDR_KEY;

  // Request only once the check is over and the port is ours
  assign bus_req_o = access & rom_rd & ~busy & chk_done_i & bus_gnt_i;

  // Status, writes and locked-out reads answer in the first access cycle
  // ROM reads before done simply stall
  assign imm_ready = access & ~busy & (pwrite_i | is_status | (chk_done_i & ~bus_gnt_i));

  // Code bits checked against the data field
  assign rd_word  = bus_rdata_i;
  assign ecc_bad  = (rd_word.fields.ecc != ecc_code(rd_word.fields.data));
  assign rsp_take = pend_q & bus_rvalid_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_q    <= 1'b0;
      rsp_q     <= 1'b0;
      rsp_err_q <= 1'b0;
    end else begin
      if (bus_req_o) begin
        pend_q <= 1'b1;
      end else if (rsp_take) begin
        pend_q <= 1'b0;
      end
      rsp_q <= rsp_take;
      if (rsp_take) begin
        rsp_err_q <= ecc_bad;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rsp_take) begin
      rsp_data_q <= rd_word.fields.data;
    end
  end

  assign pready_o  = rsp_q | imm_ready;
  // Everything but a status read answered at once is an error
  assign pslverr_o = rsp_q ? rsp_err_q : (imm_ready & (pwrite_i | ~is_status));

  // Zero data on any error
  always_comb begin
    if (rsp_q) begin
      prdata_o = rsp_err_q ? 32'h0 : rsp_data_q;
    end else if (is_status && !pwrite_i) begin
      prdata_o = {29'h0, alert_i, chk_pass_i, chk_done_i};
    end else begin
      prdata_o = 32'h0;
    end
  end

endmodule

`default_nettype wire

/* rtl/rom_guard_top.sv */
// ================================================
// Guarded boot ROM top level
// Checker, port mux, ROM array and APB slave
// ================================================

`default_nettype none

`include "rom_guard_defs.svh"

module rom_guard_top
  import rom_guard_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic [7:0]  paddr_i,
  input  logic        psel_i,
  input  logic        penable_i,
  input  logic        pwrite_i,
  input  logic [31:0] pwdata_i,
  output logic [31:0] prdata_o,
  output logic        pready_o,
  output logic        pslverr_o,
  input  sel4_t       lc_bus_en_i,
  output logic        alert_o
);

  // APB side of the mux
  logic [`ROM_AW-1:0] bus_rom_addr;
  logic [`ROM_AW-1:0] bus_prince_addr;
  logic               bus_req;
  logic               bus_gnt;
  logic [`ROM_DW-1:0] bus_rdata;
  logic               bus_rvalid;

  // Checker side of the mux
  logic [`ROM_AW-1:0] chk_addr;
  logic               chk_req;
  logic [`ROM_DW-1:0] chk_rdata;
  sel4_t              sel_bus;
  logic               chk_done;
  logic               chk_pass;

  // ROM side of the mux
  logic [`ROM_AW-1:0] rom_rom_addr;
  logic [`ROM_AW-1:0] rom_prince_addr;
  logic               rom_req;
  logic [`ROM_DW-1:0] rom_scr_rdata;
  logic [`ROM_DW-1:0] rom_clr_rdata;
  logic               rom_rvalid;

  rom_guard_checker u_checker (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .lc_bus_en_i (lc_bus_en_i),
    .chk_addr_o  (chk_addr),
    .chk_req_o   (chk_req),
    .chk_rdata_i (chk_rdata),
    .sel_bus_o   (sel_bus),
    .chk_done_o  (chk_done),
    .chk_pass_o  (chk_pass)
  );

  rom_guard_mux u_mux (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .sel_bus_i         (sel_bus),
    .bus_rom_addr_i    (bus_rom_addr),
    .bus_prince_addr_i (bus_prince_addr),
    .bus_req_i         (bus_req),
    .bus_gnt_o         (bus_gnt),
    .bus_rdata_o       (bus_rdata),
    .bus_rvalid_o      (bus_rvalid),
    .chk_addr_i        (chk_addr),
    .chk_req_i         (chk_req),
    .chk_rdata_o       (chk_rdata),
    .rom_rom_addr_o    (rom_rom_addr),
    .rom_prince_addr_o (rom_prince_addr),
    .rom_req_o         (rom_req),
    .rom_scr_rdata_i   (rom_scr_rdata),
    .rom_clr_rdata_i   (rom_clr_rdata),
    .rom_rvalid_i      (rom_rvalid),
    .alert_o           (alert_o)
  );

  rom_guard_mem u_mem (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .rom_addr_i    (rom_rom_addr),
    .prince_addr_i (rom_prince_addr),
    .req_i         (rom_req),
    .scr_rdata_o   (rom_scr_rdata),
    .clr_rdata_o   (rom_clr_rdata),
    .rvalid_o      (rom_rvalid)
  );

  // Alert also feeds the status word
  rom_guard_apb u_apb (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .paddr_i           (paddr_i),
    .psel_i            (psel_i),
    .penable_i         (penable_i),
    .pwrite_i          (pwrite_i),
    .pwdata_i          (pwdata_i),
    .prdata_o          (prdata_o),
    .pready_o          (pready_o),
    .pslverr_o         (pslverr_o),
    .chk_done_i        (chk_done),
    .chk_pass_i        (chk_pass),
    .alert_i           (alert_o),
    .bus_rom_addr_o    (bus_rom_addr),
    .bus_prince_addr_o (bus_prince_addr),
    .bus_req_o         (bus_req),
    .bus_gnt_i         (bus_gnt),
    .bus_rdata_i       (bus_rdata),
    .bus_rvalid_i      (bus_rvalid)
  );

endmodule

`default_nettype wire

/* verif/tb_rom_guard.sv */
// ================================================
// Guarded boot ROM testbench
// Random APB reads and writes, life-cycle enable
// changes, a reference model of the ROM image,
// digest, descramble, check code and alert
// ================================================

`default_nettype none

`include "rom_guard_defs.svh"

module tb_rom_guard
  import rom_guard_pkg::*;
();

  // Transfer counts per kind, shared by the loops and the run limit
  localparam int N_RAND_RD   = 200;
  localparam int N_LOCKED_RD = 20;
  localparam int N_WR        = 20;
  localparam int N_LATE_RD   = 10;
  // Single reads, status reads after enable changes and done polls
  localparam int N_OTHER     = 40;
  localparam int N_TXN       = N_RAND_RD + N_LOCKED_RD + N_WR + N_LATE_RD + N_OTHER;
  localparam int MAX_CYCLE   = N_TXN * 6 + 200;

  logic        clk_i;
  logic        rst_ni;
  logic [7:0]  paddr_i;
  logic        psel_i;
  logic        penable_i;
  logic        pwrite_i;
  logic [31:0] pwdata_i;
  logic [31:0] prdata_o;
  logic        pready_o;
  logic        pslverr_o;
  sel4_t       lc_bus_en_i;
  logic        alert_o;

  // Model state
  logic [`ROM_DW-1:0] img [`ROM_WORDS];
  logic               pass_m;
  logic               reg_true_m;
  logic               alert_m;
  integer             seed;
  int                 cycles;

  rom_guard_top u_dut (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .paddr_i     (paddr_i),
    .psel_i      (psel_i),
    .penable_i   (penable_i),
    .pwrite_i    (pwrite_i),
    .pwdata_i    (pwdata_i),
    .prdata_o    (prdata_o),
    .pready_o    (pready_o),
    .pslverr_o   (pslverr_o),
    .lc_bus_en_i (lc_bus_en_i),
    .alert_o     (alert_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // Hang guard
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles > MAX_CYCLE) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLE);
      $display("TEST FAIL");
      $fatal(1);
    end
  end

  // Key rotated one bit at a time
  function automatic logic [`ROM_DW-1:0] rotated_key(input logic [4:0] addr);
    logic [`ROM_DW-1:0] k;
    k = `ROM_DATA_KEY;
    for (int i = 0; i < addr; i++) begin
      k = {k[`ROM_DW-2:0], k[`ROM_DW-1]};
    end
    return k;
  endfunction

  // XOR of the four data bytes, bit by bit
  function automatic logic [6:0] byte_fold_code(input logic [31:0] d);
    logic [6:0] c;
    c = '0;
    for (int b = 0; b < 7; b++) begin
      c[b] = d[b] ^ d[b+8] ^ d[b+16] ^ d[b+24];
    end
    return c;
  endfunction

  function automatic logic digest_matches();
    logic [`ROM_DW-1:0] d;
    d = '0;
    for (int i = 0; i < `ROM_WORDS - 1; i++) begin
      d = {d[`ROM_DW-2:0], d[`ROM_DW-1]} ^ img[i];
    end
    return d == img[`ROM_WORDS-1];
  endfunction

  // Invalid encoding or a step back from True
  function automatic logic alert_cause(input logic reg_true, input sel4_t sel);
    return ((sel != `SEL_TRUE) && (sel != `SEL_FALSE)) || (reg_true && (sel == `SEL_FALSE));
  endfunction

  task automatic check_data(input logic [31:0] exp, input logic [31:0] act, input string name);
    if (exp !== act) begin
      $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
      $display("TEST FAIL");
      $fatal(1);
    end
  endtask

  task automatic check_err(input logic exp, input logic act, input string name);
    if (exp !== act) begin
      $display("Mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
      $display("TEST FAIL");
      $fatal(1);
    end
  endtask

  task automatic check_status(input logic [2:0] exp, input logic [2:0] act);
    if (exp !== act) begin
      $display("Mismatch at %0t: status {alert,pass,done} expected %b got %b", $time, exp, act);
      $display("TEST FAIL");
      $fatal(1);
    end
  endtask

  task automatic check_alert(input logic exp, input logic act);
    if (exp !== act) begin
      $display("Mismatch at %0t: alert_o expected %b got %b", $time, exp, act);
      $display("TEST FAIL");
      $fatal(1);
    end
  endtask

  // One APB transfer with the response sampled at the falling edge
  task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    @(posedge clk_i);
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    pwrite_i  <= wr;
    paddr_i   <= addr;
    pwdata_i  <= wdata;
    @(posedge clk_i);
    penable_i <= 1'b1;
    @(negedge clk_i);
    while (!pready_o) begin
      @(negedge clk_i);
    end
    rdata = prdata_o;
    err   = pslverr_o;
    @(posedge clk_i);
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
  endtask

  task automatic read_status(output logic [2:0] st);
    logic [31:0] d;
    logic        e;
    apb_xfer(1'b0, `STATUS_ADDR, 32'h0, d, e);
    check_err(1'b0, e, "pslverr on status");
    st = d[2:0];
  endtask

  // Poll status until the check is over and then check the whole word
  task automatic wait_done();
    logic [2:0] st;
    st = '0;
    while (!st[0]) begin
      read_status(st);
    end
    reg_true_m = pass_m && (lc_bus_en_i == `SEL_TRUE);
    check_status({alert_m, pass_m, 1'b1}, st);
  endtask

  task automatic rom_read_check(input logic [4:0] word);
    logic [31:0]        d;
    logic               e;
    logic [`ROM_DW-1:0] cw;
    logic               exp_err;
    logic [31:0]        exp_data;
    apb_xfer(1'b0, {1'b0, word, 2'b00}, 32'h0, d, e);
    cw       = img[word ^ `ROM_ADDR_KEY] ^ rotated_key(word);
    exp_err  = !reg_true_m || (byte_fold_code(cw[31:0]) != cw[38:32]);
    exp_data = exp_err ? 32'h0 : cw[31:0];
    check_err(exp_err, e, "pslverr on ROM read");
    check_data(exp_data, d, "prdata");
  endtask

  // Enable change after done with the alert registered within two cycles
  task automatic set_lc(input sel4_t v);
    logic [2:0] st;
    sel4_t      fwd;
    // Checker forwards the enable only after a passing check
    fwd = pass_m ? v : `SEL_FALSE;
    @(posedge clk_i);
    lc_bus_en_i <= v;
    alert_m    = alert_m | alert_cause(reg_true_m, fwd);
    reg_true_m = reg_true_m | (fwd == `SEL_TRUE);
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    check_alert(alert_m, alert_o);
    read_status(st);
    check_status({alert_m, pass_m, 1'b1}, st);
  endtask

  task automatic apply_reset(input sel4_t lc);
    @(posedge clk_i);
    rst_ni      <= 1'b0;
    lc_bus_en_i <= lc;
    repeat (10) @(posedge clk_i);
    rst_ni     <= 1'b1;
    alert_m    = 1'b0;
    reg_true_m = 1'b0;
  endtask

  initial begin
    logic [31:0] d;
    logic        e;
    logic [2:0]  st;
    sel4_t       bad;
    seed        = 32'h7152_c52b;
    cycles      = 0;
    rst_ni      <= 1'b0;
    paddr_i     <= '0;
    psel_i      <= 1'b0;
    penable_i   <= 1'b0;
    pwrite_i    <= 1'b0;
    pwdata_i    <= '0;
    lc_bus_en_i <= `SEL_TRUE;
    $readmemh("rom_init.hex", img);
    pass_m = digest_matches();

    // Early read stalls until the check hands over the port
    apply_reset(`SEL_TRUE);
    reg_true_m = pass_m;
    rom_read_check(5'd0);
    // Done must already be set once the stalled read has answered
    read_status(st);
    check_status({alert_m, pass_m, 1'b1}, st);
    repeat (N_RAND_RD) begin
      rom_read_check(5'($random(seed)));
    end
    check_alert(1'b0, alert_o);

    // Locked out bus followed by writes and an invalid enable
    apply_reset(`SEL_FALSE);
    wait_done();
    repeat (N_LOCKED_RD) begin
      rom_read_check(5'($random(seed)));
    end
    repeat (N_WR) begin
      apb_xfer(1'b1, 8'($random(seed)), $random(seed), d, e);
      check_err(1'b1, e, "pslverr on write");
    end
    bad = `SEL_TRUE;
    while ((bad == `SEL_TRUE) || (bad == `SEL_FALSE)) begin
      bad = 4'($random(seed));
    end
    set_lc(bad);
    set_lc(`SEL_FALSE);
    rom_read_check(5'($random(seed)));

    // True then False keeps the port with the bus
    apply_reset(`SEL_TRUE);
    wait_done();
    rom_read_check(5'd0);
    set_lc(`SEL_FALSE);
    repeat (N_LATE_RD) begin
      rom_read_check(5'($random(seed)));
    end
    check_alert(1'b1, alert_o);

    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire
